// File: src/cpuTypes.sv
package cpuTypes;

    // data word, instruction word or byte address
    typedef logic [31:0] word_t;

    // register index
    typedef logic [4:0] regbits_t;

    // primary opcodes, instr[31:26]
    typedef enum logic [5:0] {
        RTYPE = 6'h00,
        J     = 6'h02,
        JAL   = 6'h03,
        BEQ   = 6'h04,
        BNE   = 6'h05,
        ADDI  = 6'h08,
        ADDIU = 6'h09,
        SLTI  = 6'h0A,
        SLTIU = 6'h0B,
        ANDI  = 6'h0C,
        ORI   = 6'h0D,
        XORI  = 6'h0E,
        LUI   = 6'h0F,
        LW    = 6'h23,
        SW    = 6'h2B,
        HALT  = 6'h3F
    } opcode_t;

    // R-type function codes, instr[5:0]
    typedef enum logic [5:0] {
        SLLV = 6'h04,
        SRLV = 6'h06,
        JR   = 6'h08,
        ADD  = 6'h20,
        ADDU = 6'h21,
        SUB  = 6'h22,
        SUBU = 6'h23,
        AND  = 6'h24,
        OR   = 6'h25,
        XOR  = 6'h26,
        NOR  = 6'h27
    } funct_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SLT,
        ALU_SLTU
    } aluop_t;

    // instruction phases of the sequencer
    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        MEMORY,
        WRITEBACK,
        HALTED
    } busState_t;

endpackage

// File: src/controlUnit.sv
`timescale 1ns/1ns

module controlUnit (
    input  cpuTypes::word_t    instr,
    output cpuTypes::opcode_t  opcode,
    output cpuTypes::funct_t   funct,
    output cpuTypes::regbits_t regRs,
    output cpuTypes::regbits_t regRt,
    output cpuTypes::regbits_t regRd,
    output logic [15:0]        immAddr,
    output logic [25:0]        jAddr,
    output cpuTypes::aluop_t   aluCtr,
    output logic               regDst,
    output logic               regWr,
    output logic               extOp,
    output logic               aluSrc,
    output logic               memToReg,
    output logic               dREN,
    output logic               dWEN,
    output logic               beqS,
    output logic               bneS,
    output logic               jumpS,
    output logic               jalS,
    output logic               jrS,
    output logic               lui,
    output logic               halt
);

    // field split
    assign opcode  = cpuTypes::opcode_t'(instr[31:26]);
    assign regRs   = instr[25:21];
    assign regRt   = instr[20:16];
    assign regRd   = instr[15:11];
    assign immAddr = instr[15:0];
    assign jAddr   = instr[25:0];
    assign funct   = cpuTypes::funct_t'(instr[5:0]);

    always_comb begin
        // everything inactive unless an opcode claims it
        regDst   = 1'b0;
        regWr    = 1'b0;
        extOp    = 1'b0;
        aluSrc   = 1'b0;
        memToReg = 1'b0;
        dREN     = 1'b0;
        dWEN     = 1'b0;
        beqS     = 1'b0;
        bneS     = 1'b0;
        jumpS    = 1'b0;
        jalS     = 1'b0;
        jrS      = 1'b0;
        lui      = 1'b0;
        halt     = 1'b0;
        aluCtr   = cpuTypes::ALU_ADD;
        case (opcode)
            cpuTypes::RTYPE: begin
                regWr  = 1'b1;
                regDst = 1'b1;
                case (funct)
                    cpuTypes::SLLV: aluCtr = cpuTypes::ALU_SLL;
                    cpuTypes::SRLV: aluCtr = cpuTypes::ALU_SRL;
                    cpuTypes::ADD,
                    cpuTypes::ADDU: aluCtr = cpuTypes::ALU_ADD;
                    cpuTypes::SUB,
                    cpuTypes::SUBU: aluCtr = cpuTypes::ALU_SUB;
                    cpuTypes::AND:  aluCtr = cpuTypes::ALU_AND;
                    cpuTypes::OR:   aluCtr = cpuTypes::ALU_OR;
                    cpuTypes::XOR:  aluCtr = cpuTypes::ALU_XOR;
                    cpuTypes::NOR:  aluCtr = cpuTypes::ALU_NOR;
                    cpuTypes::JR: begin
                        // target comes straight from rs
                        regWr = 1'b0;
                        jrS   = 1'b1;
                    end
                    default: regWr = 1'b0;
                endcase
            end
            cpuTypes::J: jumpS = 1'b1;
            cpuTypes::JAL: begin
                regWr  = 1'b1;
                regDst = 1'b1;
                jalS   = 1'b1;
            end
            cpuTypes::BEQ, cpuTypes::BNE: begin
                // compare by subtraction, zero flag decides
                beqS   = (opcode == cpuTypes::BEQ);
                bneS   = (opcode == cpuTypes::BNE);
                aluCtr = cpuTypes::ALU_SUB;
            end
            cpuTypes::ADDI, cpuTypes::ADDIU: begin
                regWr  = 1'b1;
                extOp  = 1'b1;
                aluSrc = 1'b1;
            end
            cpuTypes::SLTI, cpuTypes::SLTIU: begin
                regWr  = 1'b1;
                extOp  = 1'b1;
                aluSrc = 1'b1;
                aluCtr = (opcode == cpuTypes::SLTI) ? cpuTypes::ALU_SLT : cpuTypes::ALU_SLTU;
            end
            cpuTypes::ANDI, cpuTypes::ORI, cpuTypes::XORI: begin
                // logic immediates are zero extended
                regWr  = 1'b1;
                aluSrc = 1'b1;
                if (opcode == cpuTypes::ANDI) begin
                    aluCtr = cpuTypes::ALU_AND;
                end else if (opcode == cpuTypes::ORI) begin
                    aluCtr = cpuTypes::ALU_OR;
                end else begin
                    aluCtr = cpuTypes::ALU_XOR;
                end
            end
            cpuTypes::LUI: begin
                regWr = 1'b1;
                lui   = 1'b1;
            end
            cpuTypes::LW: begin
                regWr    = 1'b1;
                extOp    = 1'b1;
                aluSrc   = 1'b1;
                memToReg = 1'b1;
                dREN     = 1'b1;
            end
            cpuTypes::SW: begin
                extOp  = 1'b1;
                aluSrc = 1'b1;
                dWEN   = 1'b1;
            end
            cpuTypes::HALT: halt = 1'b1;
            default: ;
        endcase
    end

endmodule

// File: src/aluUnit.sv
`timescale 1ns/1ns

module aluUnit (
    input  cpuTypes::word_t  portA,
    input  cpuTypes::word_t  portB,
    input  cpuTypes::aluop_t aluCtr,
    output cpuTypes::word_t  result,
    output logic             zero
);

    // shift amount from rs, as SLLV and SRLV use it
    logic [4:0] shamt;

    assign shamt = portA[4:0];

    always_comb begin
        case (aluCtr)
            cpuTypes::ALU_ADD:  result = portA + portB;
            cpuTypes::ALU_SUB:  result = portA - portB;
            cpuTypes::ALU_AND:  result = portA & portB;
            cpuTypes::ALU_OR:   result = portA | portB;
            cpuTypes::ALU_XOR:  result = portA ^ portB;
            cpuTypes::ALU_NOR:  result = ~(portA | portB);
            cpuTypes::ALU_SLL:  result = portB << shamt;
            cpuTypes::ALU_SRL:  result = portB >> shamt;
            cpuTypes::ALU_SLT: begin
                result = {31'b0, $signed(portA) < $signed(portB)};
            end
            cpuTypes::ALU_SLTU: begin
                result = {31'b0, portA < portB};
            end
            default: result = '0;
        endcase
    end

    // branch compare
    assign zero = (result == '0);

endmodule

// File: src/registerFile.sv
`timescale 1ns/1ns

module registerFile (
    input  logic               clk,
    input  logic               rstN,
    input  logic               wEn,
    input  cpuTypes::regbits_t wSel,
    input  cpuTypes::regbits_t rSel1,
    input  cpuTypes::regbits_t rSel2,
    input  cpuTypes::word_t    wData,
    output cpuTypes::word_t    rData1,
    output cpuTypes::word_t    rData2
);

    cpuTypes::word_t regs [32];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wEn && (wSel != '0)) begin
            // r0 never written, stays zero
            regs[wSel] <= wData;
        end
    end

    assign rData1 = regs[rSel1];
    assign rData2 = regs[rSel2];

endmodule

// File: src/busMaster.sv
`timescale 1ns/1ns

module busMaster (
    input  logic clk,
    input  logic rstN,
    input  logic wbAck,
    input  logic dREN,
    input  logic dWEN,
    input  logic halt,
    output logic wbCyc,
    output logic wbStb,
    output logic wbWe,
    output logic instrLoad,
    output logic memDone,
    output logic commit,
    output logic halted
);

    cpuTypes::busState_t state;

    // request and direction held until ack
    logic busReq;
    logic weReg;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state  <= cpuTypes::FETCH;
            busReq <= 1'b0;
            weReg  <= 1'b0;
        end else begin
            case (state)
                cpuTypes::FETCH: begin
                    if (busReq && wbAck) begin
                        state  <= cpuTypes::DECODE;
                        busReq <= 1'b0;
                    end else begin
                        // first fetch after reset raises the request here
                        busReq <= 1'b1;
                    end
                end
                cpuTypes::DECODE: begin
                    if (dREN || dWEN) begin
                        state  <= cpuTypes::MEMORY;
                        busReq <= 1'b1;
                        weReg  <= dWEN;
                    end else begin
                        state <= cpuTypes::WRITEBACK;
                    end
                end
                cpuTypes::MEMORY: begin
                    if (wbAck) begin
                        state  <= cpuTypes::WRITEBACK;
                        busReq <= 1'b0;
                        weReg  <= 1'b0;
                    end
                end
                cpuTypes::WRITEBACK: begin
                    if (halt) begin
                        state <= cpuTypes::HALTED;
                    end else begin
                        state  <= cpuTypes::FETCH;
                        busReq <= 1'b1;
                    end
                end
                cpuTypes::HALTED: busReq <= 1'b0;
                default: begin
                    state  <= cpuTypes::FETCH;
                    busReq <= 1'b0;
                    weReg  <= 1'b0;
                end
            endcase
        end
    end

    assign wbCyc = busReq;
    assign wbStb = busReq;
    assign wbWe  = weReg;

    // phase strobes for the datapath
    assign instrLoad = (state == cpuTypes::FETCH) && busReq && wbAck;
    assign memDone   = (state == cpuTypes::MEMORY) && wbAck;
    assign commit    = (state == cpuTypes::WRITEBACK);
    assign halted    = (state == cpuTypes::HALTED);

endmodule

// File: src/mipsCore.sv
`timescale 1ns/1ns

module mipsCore #(
    parameter cpuTypes::word_t resetVector = '0
) (
    input  logic            clk,
    input  logic            rstN,
    output logic            wbCyc,
    output logic            wbStb,
    output logic            wbWe,
    output cpuTypes::word_t wbAdr,
    output cpuTypes::word_t wbDatW,
    input  cpuTypes::word_t wbDatR,
    input  logic            wbAck,
    output logic            halt
);

    cpuTypes::word_t pc, pcPlus4, nextPc, instrReg, loadData;
    cpuTypes::word_t extImm, aluB, aluResult, rData1, rData2, wData;
    cpuTypes::regbits_t regRs, regRt, regRd, wSel;
    cpuTypes::aluop_t aluCtr;
    logic [15:0] immAddr;
    logic [25:0] jAddr;
    logic regDst, regWr, extOp, aluSrc, memToReg, dREN, dWEN;
    logic beqS, bneS, jumpS, jalS, jrS, lui, haltInstr;
    logic zero, branchTaken;
    logic instrLoad, memDone, commit;
    // high from commit until the next instruction is in
    logic fetching;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc       <= resetVector;
            fetching <= 1'b1;
        end else if (commit) begin
            pc       <= nextPc;
            fetching <= 1'b1;
        end else if (instrLoad) begin
            fetching <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (instrLoad) begin
            instrReg <= wbDatR;
        end
        if (memDone && dREN) begin
            loadData <= wbDatR;
        end
    end

    controlUnit controlUnit_inst (
        .instr(instrReg), .opcode(), .funct(),
        .regRs(regRs), .regRt(regRt), .regRd(regRd),
        .immAddr(immAddr), .jAddr(jAddr), .aluCtr(aluCtr),
        .regDst(regDst), .regWr(regWr), .extOp(extOp), .aluSrc(aluSrc),
        .memToReg(memToReg), .dREN(dREN), .dWEN(dWEN),
        .beqS(beqS), .bneS(bneS), .jumpS(jumpS), .jalS(jalS), .jrS(jrS),
        .lui(lui), .halt(haltInstr)
    );

    assign extImm = extOp ? {{16{immAddr[15]}}, immAddr} : {16'b0, immAddr};
    assign aluB   = aluSrc ? extImm : rData2;

    aluUnit aluUnit_inst (
        .portA(rData1), .portB(aluB), .aluCtr(aluCtr),
        .result(aluResult), .zero(zero)
    );

    // JAL links into r31
    assign wSel = jalS ? 5'd31 : (regDst ? regRd : regRt);

    always_comb begin
        if (jalS) begin
            wData = pcPlus4;
        end else if (lui) begin
            wData = {immAddr, 16'b0};
        end else if (memToReg) begin
            wData = loadData;
        end else begin
            wData = aluResult;
        end
    end

    registerFile registerFile_inst (
        .clk(clk), .rstN(rstN), .wEn(commit && regWr), .wSel(wSel),
        .rSel1(regRs), .rSel2(regRt), .wData(wData),
        .rData1(rData1), .rData2(rData2)
    );

    // next PC, jump first, then jr, then taken branch
    assign pcPlus4     = pc + 32'd4;
    assign branchTaken = (beqS && zero) || (bneS && !zero);

    always_comb begin
        if (jumpS || jalS) begin
            nextPc = {pcPlus4[31:28], jAddr, 2'b00};
        end else if (jrS) begin
            nextPc = rData1;
        end else if (branchTaken) begin
            // branch offset is always sign extended
            nextPc = pcPlus4 + {{14{immAddr[15]}}, immAddr, 2'b00};
        end else begin
            nextPc = pcPlus4;
        end
    end

    busMaster busMaster_inst (
        .clk(clk), .rstN(rstN), .wbAck(wbAck),
        .dREN(dREN), .dWEN(dWEN), .halt(haltInstr),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
        .instrLoad(instrLoad), .memDone(memDone), .commit(commit),
        .halted(halt)
    );

    // PC for fetch, effective address for LW and SW
    assign wbAdr  = fetching ? pc : aluResult;
    assign wbDatW = rData2;

endmodule

// File: test/mipsCore_properties.sv
`timescale 1ns/1ns

module mipsCore_properties (
    input logic            clk,
    input logic            rstN,
    input logic            wbCyc,
    input logic            wbStb,
    input logic            wbWe,
    input logic            wbAck,
    input logic            halt,
    input cpuTypes::word_t wbAdr,
    input cpuTypes::word_t wbDatW
);

    // strobe only inside a bus cycle
    stbInCyc: assert property (@(posedge clk) disable iff (!rstN) wbStb |-> wbCyc)
        else $error("wbStb high without wbCyc");

    // request held unchanged through wait states
    holdWhileWaiting: assert property (@(posedge clk) disable iff (!rstN)
        (wbStb && !wbAck) |=> (wbStb && $stable(wbAdr) && $stable(wbDatW) && $stable(wbWe)))
        else $error("bus request changed before wbAck");

    // halted core stays off the bus
    quietAfterHalt: assert property (@(posedge clk) disable iff (!rstN)
        halt |-> (!wbCyc && !wbStb))
        else $error("bus request while halted");

endmodule

// File: test/mipsCoreTb.sv
`timescale 1ns/1ns

module mipsCoreTb;

    localparam int numInstr = 200;
    // random body ends where the register dump starts
    localparam int bodyEnd = numInstr - 32;
    // worst case is about 12 cycles per instruction with 3 wait states
    localparam int watchdogNs = numInstr * 12 * 10 + 2000;
    localparam logic [5:0] rFuncts [10] = '{
        cpuTypes::ADD, cpuTypes::ADDU, cpuTypes::SUB, cpuTypes::SUBU, cpuTypes::AND,
        cpuTypes::OR, cpuTypes::XOR, cpuTypes::NOR, cpuTypes::SLLV, cpuTypes::SRLV
    };
    localparam logic [5:0] immOps [8] = '{
        cpuTypes::ADDI, cpuTypes::ADDIU, cpuTypes::SLTI, cpuTypes::SLTIU,
        cpuTypes::ANDI, cpuTypes::ORI, cpuTypes::XORI, cpuTypes::LUI
    };

    logic clk = 1'b0;
    logic rstN = 1'b0;
    logic wbAck = 1'b0;
    logic wbCyc;
    logic wbStb;
    logic wbWe;
    logic halt;
    cpuTypes::word_t wbAdr;
    cpuTypes::word_t wbDatW;
    cpuTypes::word_t wbDatR = '0;

    cpuTypes::word_t progImage [4096];
    cpuTypes::word_t mem [4096];
    cpuTypes::word_t modelMem [4096];
    cpuTypes::word_t modelRegs [32];
    // expected bus transfers in order including fetches
    logic expWe [1024];
    cpuTypes::word_t expAdr [1024];
    cpuTypes::word_t expDat [1024];
    int waitTable [1024];
    int expCount = 0;
    int xferIdx = 0;
    int waitLeft = 0;
    int seed;

    mipsCore #(.resetVector(32'h0)) mipsCore_inst (
        .clk(clk), .rstN(rstN), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
        .wbAdr(wbAdr), .wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck), .halt(halt)
    );

    bind mipsCore mipsCore_properties mipsCore_properties_inst (
        .clk(clk), .rstN(rstN), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
        .wbAck(wbAck), .halt(halt), .wbAdr(wbAdr), .wbDatW(wbDatW)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    function automatic int randBelow(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fffffff) % n;
    endfunction

    function automatic cpuTypes::word_t rType(input int rs, input int rt, input int rd,
                                              input logic [5:0] fn);
        return {6'h00, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
    endfunction

    function automatic cpuTypes::word_t iType(input logic [5:0] op, input int rs, input int rt,
                                              input logic [15:0] imm);
        return {op, rs[4:0], rt[4:0], imm};
    endfunction

    task automatic checkEq(input string name, input cpuTypes::word_t expected,
                           input cpuTypes::word_t actual);
        if (expected !== actual) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic genProgram();
        int i;
        int kind;
        int tgt;
        int rd;
        int rs;
        int rt;
        logic [5:0] op;
        logic [15:0] imm;
        // unused words carry their own address
        for (int w = 0; w < 4096; w++) begin
            progImage[w[11:0]] = {20'hC0DE5, w[11:0]};
        end
        for (int w = 2048; w < 2304; w++) begin
            progImage[w[11:0]] = $random(seed);
        end
        for (int w = 0; w < 1024; w++) begin
            waitTable[w[9:0]] = randBelow(4);
        end
        // r30 holds the data base 8192 and is never written again
        progImage[0] = iType(cpuTypes::LUI, 0, 30, 16'h0000);
        progImage[1] = iType(cpuTypes::ORI, 30, 30, 16'h2000);
        i = 2;
        while (i < bodyEnd) begin
            kind = randBelow(10);
            rd = randBelow(29) + 1;
            rs = randBelow(32);
            rt = randBelow(32);
            imm = 16'(randBelow(65536));
            tgt = i + 1 + randBelow(6);
            if (tgt > bodyEnd) begin
                tgt = bodyEnd;
            end
            if (kind == 4 && i + 1 < bodyEnd) begin
                // load then store the loaded register right back out
                progImage[i[11:0]] = iType(cpuTypes::LW, 30, rd, 16'(randBelow(256) * 4));
                progImage[12'(i + 1)] = iType(cpuTypes::SW, 30, rd, 16'(randBelow(256) * 4));
                i = i + 2;
            end else begin
                case (kind)
                    0, 1, 8: progImage[i[11:0]] = rType(rs, rt, rd, rFuncts[4'(randBelow(10))]);
                    2, 3, 9: progImage[i[11:0]] = iType(immOps[3'(randBelow(8))], rs, rd, imm);
                    5: progImage[i[11:0]] = iType(cpuTypes::SW, 30, rt, 16'(randBelow(256) * 4));
                    6: begin
                        // equal operands now and then so BEQ gets taken
                        if (randBelow(2) == 1) begin
                            rt = rs;
                        end
                        op = (randBelow(2) == 1) ? cpuTypes::BEQ : cpuTypes::BNE;
                        progImage[i[11:0]] = iType(op, rs, rt, 16'(tgt - i - 1));
                    end
                    7: begin
                        op = (randBelow(2) == 1) ? cpuTypes::J : cpuTypes::JAL;
                        progImage[i[11:0]] = {op, 26'(tgt)};
                    end
                    default: progImage[i[11:0]] = rType(rs, rt, rd, cpuTypes::ADDU);
                endcase
                i = i + 1;
            end
        end
        // dump r1..r31 and then stop
        for (int r = 1; r < 32; r++) begin
            progImage[12'(bodyEnd + r - 1)] = iType(cpuTypes::SW, 30, r, 16'(r * 4));
        end
        progImage[12'(bodyEnd + 31)] = {cpuTypes::HALT, 26'b0};
    endtask

    task automatic addExpected(input logic we, input cpuTypes::word_t adr,
                               input cpuTypes::word_t dat);
        expWe[expCount[9:0]] = we;
        expAdr[expCount[9:0]] = adr;
        expDat[expCount[9:0]] = dat;
        expCount = expCount + 1;
    endtask

    task automatic setReg(input logic [4:0] idx, input cpuTypes::word_t value);
        if (idx != 5'd0) begin
            modelRegs[idx] = value;
        end
    endtask

    // ISA reference model with one instruction per loop pass
    task automatic runModel();
        cpuTypes::word_t pc;
        cpuTypes::word_t next;
        cpuTypes::word_t ins;
        cpuTypes::word_t a;
        cpuTypes::word_t b;
        cpuTypes::word_t sx;
        cpuTypes::word_t zx;
        cpuTypes::word_t ea;
        logic done;
        for (int w = 0; w < 4096; w++) begin
            modelMem[w[11:0]] = progImage[w[11:0]];
        end
        for (int r = 0; r < 32; r++) begin
            modelRegs[r[4:0]] = '0;
        end
        pc = '0;
        done = 1'b0;
        while (!done && expCount < 1000) begin
            ins = modelMem[pc[13:2]];
            addExpected(1'b0, pc, '0);
            a = modelRegs[ins[25:21]];
            b = modelRegs[ins[20:16]];
            sx = {{16{ins[15]}}, ins[15:0]};
            zx = {16'b0, ins[15:0]};
            ea = a + sx;
            next = pc + 32'd4;
            case (ins[31:26])
                cpuTypes::RTYPE: begin
                    case (ins[5:0])
                        cpuTypes::ADD, cpuTypes::ADDU: setReg(ins[15:11], a + b);
                        cpuTypes::SUB, cpuTypes::SUBU: setReg(ins[15:11], a - b);
                        cpuTypes::AND: setReg(ins[15:11], a & b);
                        cpuTypes::OR: setReg(ins[15:11], a | b);
                        cpuTypes::XOR: setReg(ins[15:11], a ^ b);
                        cpuTypes::NOR: setReg(ins[15:11], ~(a | b));
                        cpuTypes::SLLV: setReg(ins[15:11], b << a[4:0]);
                        cpuTypes::SRLV: setReg(ins[15:11], b >> a[4:0]);
                        default: ;
                    endcase
                end
                cpuTypes::ADDI, cpuTypes::ADDIU: setReg(ins[20:16], a + sx);
                cpuTypes::SLTI: setReg(ins[20:16], {31'b0, $signed(a) < $signed(sx)});
                cpuTypes::SLTIU: setReg(ins[20:16], {31'b0, a < sx});
                cpuTypes::ANDI: setReg(ins[20:16], a & zx);
                cpuTypes::ORI: setReg(ins[20:16], a | zx);
                cpuTypes::XORI: setReg(ins[20:16], a ^ zx);
                cpuTypes::LUI: setReg(ins[20:16], {ins[15:0], 16'b0});
                cpuTypes::LW: begin
                    addExpected(1'b0, ea, '0);
                    setReg(ins[20:16], modelMem[ea[13:2]]);
                end
                cpuTypes::SW: begin
                    addExpected(1'b1, ea, b);
                    modelMem[ea[13:2]] = b;
                end
                cpuTypes::BEQ: next = (a == b) ? next + (sx << 2) : next;
                cpuTypes::BNE: next = (a != b) ? next + (sx << 2) : next;
                cpuTypes::J: next = {next[31:28], ins[25:0], 2'b00};
                cpuTypes::JAL: begin
                    setReg(5'd31, next);
                    next = {next[31:28], ins[25:0], 2'b00};
                end
                default: done = 1'b1;
            endcase
            pc = next;
        end
    endtask

    task automatic checkTransfer(input int idx);
        if (idx >= expCount) begin
            $display("Error: bus transfer at address %h after the program should have ended",
                     wbAdr);
            $display("Simulation failed");
            $fatal(1, "unexpected bus transfer");
        end else begin
            checkEq($sformatf("transfer %0d direction", idx), {31'b0, expWe[idx[9:0]]},
                    {31'b0, wbWe});
            checkEq($sformatf("transfer %0d address", idx), expAdr[idx[9:0]], wbAdr);
            if (expWe[idx[9:0]]) begin
                checkEq($sformatf("transfer %0d store data", idx), expDat[idx[9:0]], wbDatW);
            end
        end
    endtask

    // Wishbone slave with 0 to 3 wait states per transfer
    always @(posedge clk) begin
        if (!rstN) begin
            for (int w = 0; w < 4096; w++) begin
                mem[w[11:0]] = progImage[w[11:0]];
            end
            wbAck <= 1'b0;
            xferIdx <= 0;
            waitLeft <= waitTable[0];
        end else if (wbAck) begin
            wbAck <= 1'b0;
        end else if (wbCyc && wbStb) begin
            if (waitLeft != 0) begin
                waitLeft <= waitLeft - 1;
            end else begin
                checkTransfer(xferIdx);
                if (wbWe) begin
                    mem[wbAdr[13:2]] = wbDatW;
                end else begin
                    wbDatR <= mem[wbAdr[13:2]];
                end
                wbAck <= 1'b1;
                xferIdx <= xferIdx + 1;
                waitLeft <= waitTable[10'(xferIdx + 1)];
            end
        end
    end

    initial begin
        #(watchdogNs);
        $display("Error: the core never halted within %0d ns", watchdogNs);
        $display("Simulation failed");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        seed = 32'h6250e113;
        genProgram();
        runModel();
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
        while (!halt) @(negedge clk);
        // HALT fetch must have been the last transfer
        checkEq("transfer count at halt", cpuTypes::word_t'(expCount),
                cpuTypes::word_t'(xferIdx));
        repeat (8) begin
            @(negedge clk);
            checkEq("wbCyc after halt", '0, {31'b0, wbCyc});
            checkEq("wbStb after halt", '0, {31'b0, wbStb});
            checkEq("halt held high", 32'd1, {31'b0, halt});
        end
        for (int r = 1; r < 32; r++) begin
            checkEq($sformatf("final r%0d", r), modelRegs[r[4:0]],
                    mipsCore_inst.registerFile_inst.regs[r[4:0]]);
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

// File: all.f
src/cpuTypes.sv
src/controlUnit.sv
src/aluUnit.sv
src/registerFile.sv
src/busMaster.sv
src/mipsCore.sv
test/mipsCore_properties.sv
test/mipsCoreTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the mipsCore testbench with Verilator.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir

if ! verilator --binary --timing --assert --top-module mipsCoreTb -f all.f -o mipsCoreSim; then
    echo "verilator build step returned an error"
    exit 1
fi

if ! ./obj_dir/mipsCoreSim; then
    echo "simulation run returned an error"
    exit 1
fi

exit 0
